// File: common/opp_pkg.sv
package opp_pkg;

	////////////////////////////////////////
	// shared constants
	////////////////////////////////////////

	// width of the unsigned output factor
	// also the front-panel multiplier field width
	localparam int MULT_W = 8;

	////////////////////////////////////////
	// sequencer states
	////////////////////////////////////////

	// one sample in flight at a time
	// idle -> compute -> send -> done -> idle
	typedef enum logic [1:0] {
		st_idle    = 2'd0,	// waiting for a sample strobe
		st_compute = 2'd1,	// datapath settling, result latched at end
		st_send    = 2'd2,	// output word valid for one cycle
		st_done    = 2'd3	// output written back as previous value
	} opp_state_e;

endpackage

// File: common/opp_param_if.sv
`timescale 1ns/1ps

interface opp_param_if #(
	parameter int W_OUT = 16	// output word width
);

	////////////////////////////////////////
	// active front-panel parameters
	////////////////////////////////////////

	logic signed [W_OUT-1:0]          output_max;	// upper clamp bound
	logic signed [W_OUT-1:0]          output_min;	// lower clamp bound
	logic signed [W_OUT-1:0]          output_init;	// value used while unlocked
	logic        [opp_pkg::MULT_W-1:0] multiplier;	// unsigned scale factor

	// register bank owns the values
	modport bank (
		output output_max,
		output output_min,
		output output_init,
		output multiplier
	);

	// scaler, accumulator and limiter only read
	modport datapath (
		input output_max,
		input output_min,
		input output_init,
		input multiplier
	);

endinterface

// File: output_preprocessor/opp_control.sv
`timescale 1ns/1ps

module opp_control #(
	parameter int COMP_LATENCY = 3	// compute cycles, 2 or more
) (
	input  logic clk_in,		// system clock
	input  logic reset_in,		// sync reset, active high
	input  logic data_valid_in,	// sample strobe from mux
	output logic capture,		// scaler takes the sample
	output logic latch,		// limiter takes the clamped word
	output logic send,		// output word valid
	output logic commit		// accumulator takes the held word
);

	// counter runs 0..COMP_LATENCY in compute, capture cycle included
	localparam int CNT_W = $clog2(COMP_LATENCY + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(COMP_LATENCY);

	opp_pkg::opp_state_e state;		// current state
	opp_pkg::opp_state_e state_next;	// next state
	logic [CNT_W-1:0]    count;		// cycles spent in current state

	////////////////////////////////////////
	// state and counter registers
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= opp_pkg::st_idle;
			count <= '0;
		end else begin
			state <= state_next;
			if (state_next != state) begin
				count <= '0;	// clear on every transition
			end else if (state == opp_pkg::st_compute) begin
				count <= count + 1'b1;	// only compute needs counting
			end
		end
	end

	always_comb begin
		state_next = state;	// hold by default
		case (state)
			opp_pkg::st_idle: begin
				if (data_valid_in) state_next = opp_pkg::st_compute;
			end
			opp_pkg::st_compute: begin
				if (count == CNT_LAST) state_next = opp_pkg::st_send;
			end
			opp_pkg::st_send:    state_next = opp_pkg::st_done;	// single cycle
			opp_pkg::st_done:    state_next = opp_pkg::st_idle;	// single cycle
			default:             state_next = opp_pkg::st_idle;
		endcase
	end

	////////////////////////////////////////
	// strobe decode
	////////////////////////////////////////

	assign capture = (state == opp_pkg::st_idle) && data_valid_in;	// late strobes dropped
	assign latch   = (state == opp_pkg::st_compute) && (count == CNT_LAST);
	assign send    = (state == opp_pkg::st_send);
	assign commit  = (state == opp_pkg::st_done);

	// output pulse never stretches
	a_send_single: assert property (@(posedge clk_in) disable iff (reset_in)
		send |=> !send)
		else $error("send strobe held longer than one cycle");

	// write-back always right behind the output pulse
	a_commit_after_send: assert property (@(posedge clk_in) disable iff (reset_in)
		send |=> commit)
		else $error("commit did not follow send");

endmodule

// File: output_preprocessor/opp_param_bank.sv
`timescale 1ns/1ps

module opp_param_bank #(
	parameter int W_OUT      = 16,		// output word width
	parameter int OMAX_INIT  = 9999,	// reset upper bound
	parameter int OMIN_INIT  = 1111,	// reset lower bound
	parameter int OINIT_INIT = 5000,	// reset starting value
	parameter int MULT_INIT  = 1		// reset scale factor
) (
	input  logic                       clk_in,		// system clock
	input  logic                       reset_in,		// sync reset, active high
	input  logic signed [W_OUT-1:0]    output_max_in,	// front-panel upper bound
	input  logic signed [W_OUT-1:0]    output_min_in,	// front-panel lower bound
	input  logic signed [W_OUT-1:0]    output_init_in,	// front-panel starting value
	input  logic [opp_pkg::MULT_W-1:0] multiplier_in,	// front-panel factor
	input  logic                       update_en_in,	// arms the update pulse
	input  logic                       update_in,		// update pulse
	opp_param_if.bank                  params,		// active parameters
	output logic                       reload		// restart accumulation
);

	logic update_qual;	// update accepted this cycle

	assign update_qual = update_in && update_en_in;

	////////////////////////////////////////
	// parameter registers
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			params.output_max  <= W_OUT'(OMAX_INIT);
			params.output_min  <= W_OUT'(OMIN_INIT);
			params.output_init <= W_OUT'(OINIT_INIT);
			params.multiplier  <= (opp_pkg::MULT_W)'(MULT_INIT);
			reload             <= 1'b0;
		end else begin
			reload <= update_qual;	// one cycle, new values already visible
			if (update_qual) begin
				params.output_max  <= output_max_in;
				params.output_min  <= output_min_in;
				params.output_init <= output_init_in;
				params.multiplier  <= multiplier_in;
			end
		end
	end

	// crossed bounds are legal but suspicious
	a_bounds_ordered: assert property (@(posedge clk_in) disable iff (reset_in)
		reload |-> (params.output_min <= params.output_max))
		else $warning("front-panel update left min above max");

endmodule

// File: output_preprocessor/opp_scaler.sv
`timescale 1ns/1ps

module opp_scaler #(
	parameter int W_IN  = 18,	// input sample width
	parameter int W_OUT = 16	// output word width
) (
	input  logic                    clk_in,		// system clock
	input  logic                    reset_in,	// sync reset, active high
	input  logic signed [W_IN-1:0]  data_in,	// error sample from mux
	input  logic                    capture,	// sample accepted
	opp_param_if.datapath           params,		// active parameters
	output logic signed [W_OUT-1:0] scaled		// saturated scaled sample
);

	// signed product of W_OUT sample and zero-extended factor
	localparam int PROD_W = W_OUT + opp_pkg::MULT_W + 1;
	localparam logic signed [W_OUT-1:0] OUT_MAX = {1'b0, {(W_OUT-1){1'b1}}};
	localparam logic signed [W_OUT-1:0] OUT_MIN = {1'b1, {(W_OUT-1){1'b0}}};

	logic signed [W_OUT-1:0]  sample_conv;	// sample at output width
	logic signed [PROD_W-1:0] product;	// full-width product
	logic signed [W_OUT-1:0]  product_sat;	// product clipped to word range

	////////////////////////////////////////
	// width conversion
	////////////////////////////////////////

	generate
		if (W_OUT < W_IN) begin : g_trunc
			assign sample_conv = data_in[W_IN-1 -: W_OUT];	// drop lsbs
		end else begin : g_extend
			assign sample_conv = W_OUT'(data_in);	// sign extend
		end
	endgenerate

	assign product = sample_conv * $signed({1'b0, params.multiplier});

	always_comb begin
		if (product > OUT_MAX) begin
			product_sat = OUT_MAX;	// positive overflow
		end else if (product < OUT_MIN) begin
			product_sat = OUT_MIN;	// negative overflow
		end else begin
			product_sat = product[W_OUT-1:0];
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			scaled <= '0;
		end else if (capture) begin
			scaled <= product_sat;	// held for the whole compute phase
		end
	end

endmodule

// File: output_preprocessor/opp_accumulator.sv
`timescale 1ns/1ps

module opp_accumulator #(
	parameter int W_OUT      = 16,	// output word width
	parameter int OINIT_INIT = 5000	// reset starting value
) (
	input  logic                    clk_in,		// system clock
	input  logic                    reset_in,	// sync reset, active high
	input  logic signed [W_OUT-1:0] scaled,		// scaled sample from scaler
	input  logic                    lock_en_in,	// lock enabled
	input  logic                    commit,		// write back held word
	input  logic                    reload,		// restart from starting value
	input  logic signed [W_OUT-1:0] held,		// limiter output word
	opp_param_if.datapath           params,		// active parameters
	output logic signed [W_OUT-1:0] next_value	// value before clamping
);

	localparam logic signed [W_OUT-1:0] OUT_MAX = {1'b0, {(W_OUT-1){1'b1}}};
	localparam logic signed [W_OUT-1:0] OUT_MIN = {1'b1, {(W_OUT-1){1'b0}}};

	logic signed [W_OUT-1:0] prev_value;	// last output word sent
	logic signed [W_OUT-1:0] sum_raw;	// wrapping sum
	logic signed [W_OUT-1:0] sum_sat;	// saturated sum
	logic                    overflow;	// sum left the word range

	////////////////////////////////////////
	// saturating add and lock select
	////////////////////////////////////////

	assign sum_raw = scaled + prev_value;

	// same-sign operands with a flipped result sign
	assign overflow = (scaled[W_OUT-1] == prev_value[W_OUT-1])
		&& (sum_raw[W_OUT-1] != scaled[W_OUT-1]);

	always_comb begin
		if (overflow) begin
			sum_sat = scaled[W_OUT-1] ? OUT_MIN : OUT_MAX;	// toward operand sign
		end else begin
			sum_sat = sum_raw;
		end
	end

	assign next_value = lock_en_in ? sum_sat : params.output_init;	// unlocked holds init

	////////////////////////////////////////
	// previous output register
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prev_value <= W_OUT'(OINIT_INIT);	// bank resets to the same value
		end else if (reload) begin
			prev_value <= params.output_init;	// reload wins over commit
		end else if (commit) begin
			prev_value <= held;
		end
	end

endmodule

// File: output_preprocessor/opp_limiter.sv
`timescale 1ns/1ps

module opp_limiter #(
	parameter int W_OUT = 16	// output word width
) (
	input  logic                    clk_in,		// system clock
	input  logic                    reset_in,	// sync reset, active high
	input  logic signed [W_OUT-1:0] next_value,	// unclamped value
	input  logic                    latch,		// last compute cycle
	opp_param_if.datapath           params,		// active parameters
	output logic signed [W_OUT-1:0] data_out	// held output word
);

	logic signed [W_OUT-1:0] upper_clamped;	// after max bound
	logic signed [W_OUT-1:0] clamped;	// after both bounds

	// min applied last, so it wins when bounds cross
	assign upper_clamped = (next_value > params.output_max) ? params.output_max : next_value;
	assign clamped = (upper_clamped < params.output_min) ? params.output_min : upper_clamped;

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_out <= '0;
		end else if (latch) begin
			data_out <= clamped;	// holds until next latch
		end
	end

	// bounds sampled at the latch edge, an update there may move them
	a_out_in_bounds: assert property (@(posedge clk_in) disable iff (reset_in)
		latch |=> ($past(params.output_min) > $past(params.output_max))
			|| ((data_out >= $past(params.output_min))
			&& (data_out <= $past(params.output_max))))
		else $error("latched word outside active bounds");

endmodule

// File: source/lock_output_stage.sv
`timescale 1ns/1ps

module lock_output_stage #(
	parameter int W_IN         = 18,	// input sample width
	parameter int W_OUT        = 16,	// output word width
	parameter int COMP_LATENCY = 3,		// compute cycles, 2 or more
	parameter int OMAX_INIT    = 9999,	// reset upper bound
	parameter int OMIN_INIT    = 1111,	// reset lower bound
	parameter int OINIT_INIT   = 5000,	// reset starting value
	parameter int MULT_INIT    = 1		// reset scale factor
) (
	input  logic                       clk_in,		// system clock
	input  logic                       reset_in,		// sync reset, active high
	input  logic signed [W_IN-1:0]     data_in,		// error sample from mux
	input  logic                       data_valid_in,	// sample strobe
	input  logic                       lock_en_in,		// lock enable from mux
	input  logic signed [W_OUT-1:0]    output_max_in,	// front-panel upper bound
	input  logic signed [W_OUT-1:0]    output_min_in,	// front-panel lower bound
	input  logic signed [W_OUT-1:0]    output_init_in,	// front-panel starting value
	input  logic [opp_pkg::MULT_W-1:0] multiplier_in,	// front-panel factor
	input  logic                       update_en_in,	// arms update
	input  logic                       update_in,		// update pulse
	output logic signed [W_OUT-1:0]    data_out,		// word to dds or dac queue
	output logic                       data_valid_out	// one-cycle valid pulse
);

	logic                    capture;	// sample accepted
	logic                    latch;		// take clamped word
	logic                    commit;	// write back output
	logic                    reload;	// restart from new init
	logic signed [W_OUT-1:0] scaled;	// scaler result
	logic signed [W_OUT-1:0] next_value;	// accumulator result

	opp_param_if #(.W_OUT(W_OUT)) params_if ();	// bank to datapath

	////////////////////////////////////////
	// control and parameters
	////////////////////////////////////////

	opp_control #(
		.COMP_LATENCY(COMP_LATENCY)
	) u_control (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.data_valid_in (data_valid_in),
		.capture       (capture),
		.latch         (latch),
		.send          (data_valid_out),	// send strobe is the valid pulse
		.commit        (commit)
	);

	opp_param_bank #(
		.W_OUT      (W_OUT),
		.OMAX_INIT  (OMAX_INIT),
		.OMIN_INIT  (OMIN_INIT),
		.OINIT_INIT (OINIT_INIT),
		.MULT_INIT  (MULT_INIT)
	) u_param_bank (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.output_max_in  (output_max_in),
		.output_min_in  (output_min_in),
		.output_init_in (output_init_in),
		.multiplier_in  (multiplier_in),
		.update_en_in   (update_en_in),
		.update_in      (update_in),
		.params         (params_if.bank),
		.reload         (reload)
	);

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	opp_scaler #(
		.W_IN  (W_IN),
		.W_OUT (W_OUT)
	) u_scaler (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.data_in  (data_in),
		.capture  (capture),
		.params   (params_if.datapath),
		.scaled   (scaled)
	);

	opp_accumulator #(
		.W_OUT      (W_OUT),
		.OINIT_INIT (OINIT_INIT)
	) u_accumulator (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.scaled     (scaled),
		.lock_en_in (lock_en_in),
		.commit     (commit),
		.reload     (reload),
		.held       (data_out),	// previous value comes from sent word
		.params     (params_if.datapath),
		.next_value (next_value)
	);

	opp_limiter #(
		.W_OUT (W_OUT)
	) u_limiter (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.next_value (next_value),
		.latch      (latch),
		.params     (params_if.datapath),
		.data_out   (data_out)
	);

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,	// clock period
	parameter int RESET_CYCLES = 16		// rising edges held in reset
) (
	output logic clk_in,	// free-running clock
	output logic reset_in	// sync reset, active high
);

	initial begin
		clk_in = 1'b0;
		forever #(PERIOD_NS / 2) clk_in = ~clk_in;	// 50/50 duty
	end

	initial begin
		reset_in = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_in);
		@(negedge clk_in);
		reset_in <= 1'b0;	// released away from the sampling edge
	end

endmodule

// File: sim/lock_output_stage_tb.sv
`timescale 1ns/1ps

module lock_output_stage_tb;

	localparam int W_IN         = 18;
	localparam int W_OUT        = 16;
	localparam int COMP_LATENCY = 3;
	localparam int OMAX_INIT    = 9999;
	localparam int OMIN_INIT    = 1111;
	localparam int OINIT_INIT   = 5000;
	localparam int MULT_INIT    = 1;
	localparam int RESET_CYCLES = 16;
	localparam int WORD_MAX     = (1 << (W_OUT - 1)) - 1;	// signed word limits
	localparam int WORD_MIN     = -(1 << (W_OUT - 1));

	// model countdown, loaded at accept, back to zero in idle
	localparam int SEQ_CYCLES = COMP_LATENCY + 3;
	localparam int LATCH_AT   = 3;	// countdown value at the latch edge
	localparam int VALID_AT   = 2;	// countdown value while the pulse is out
	localparam int COMMIT_AT  = 1;	// countdown value at the write-back edge

	// samples per phase
	localparam int N_FIXED   = 4;
	localparam int N_DROP    = 4;
	localparam int N_SAT     = 100;
	localparam int N_NARROW  = 60;
	localparam int N_UNLOCK  = 6;
	localparam int N_RELOCK  = 6;
	localparam int N_NOLOAD  = 6;
	localparam int N_RESTART = 6;
	localparam int N_SAMPLES = N_FIXED + N_DROP + N_SAT + N_NARROW + N_UNLOCK + N_RELOCK
		+ N_NOLOAD + N_RESTART;
	localparam int MAX_CYCLES = 2 * (RESET_CYCLES + N_SAMPLES * (SEQ_CYCLES + 1) + 64);

	logic                       clk_in;
	logic                       reset_in;
	logic signed [W_IN-1:0]     data_in;
	logic                       data_valid_in;
	logic                       lock_en_in;
	logic signed [W_OUT-1:0]    output_max_in;
	logic signed [W_OUT-1:0]    output_min_in;
	logic signed [W_OUT-1:0]    output_init_in;
	logic [opp_pkg::MULT_W-1:0] multiplier_in;
	logic                       update_en_in;
	logic                       update_in;
	logic signed [W_OUT-1:0]    data_out;
	logic                       data_valid_out;

	int mismatch_errors = 0;	// value compares
	int other_errors    = 0;	// sequencing, counts, timeout
	int n_sent          = 0;	// samples the driver expects accepted
	int n_pulses        = 0;	// valid pulses seen
	int cycle_count     = 0;
	logic [31:0] lfsr;

	// reference model state
	int m_max, m_min, m_init, m_mult;	// active parameters
	int m_prev;				// previous output word
	int m_scaled;				// scaled sample at capture
	int m_cnt;				// sequence countdown
	logic m_reload;				// reload pending
	logic signed [W_OUT-1:0] exp_data;	// expected output word
	logic exp_valid;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
		.clk_in   (clk_in),
		.reset_in (reset_in)
	);

	lock_output_stage #(
		.W_IN(W_IN), .W_OUT(W_OUT), .COMP_LATENCY(COMP_LATENCY),
		.OMAX_INIT(OMAX_INIT), .OMIN_INIT(OMIN_INIT),
		.OINIT_INIT(OINIT_INIT), .MULT_INIT(MULT_INIT)
	) DUT (.*);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic int sat_word(input int v);
		if (v > WORD_MAX) return WORD_MAX;	// clip, never wrap
		if (v < WORD_MIN) return WORD_MIN;
		return v;
	endfunction

	function automatic int scale_sample(input logic signed [W_IN-1:0] s, input int mult);
		int conv;
		conv = int'(s) >>> (W_IN - W_OUT);	// top W_OUT bits of the sample
		return sat_word(conv * mult);
	endfunction

	function automatic int latch_word(input logic lock, input int scaled, input int prev,
		input int init, input int lo, input int hi);
		int v;
		v = lock ? sat_word(scaled + prev) : init;	// unlocked means starting value
		v = (v > hi) ? hi : v;	// upper bound first
		v = (v < lo) ? lo : v;	// lower bound wins on crossed bounds
		return v;
	endfunction

	assign exp_valid = (m_cnt == VALID_AT);

	always @(posedge clk_in) begin
		if (reset_in) begin
			m_max    <= OMAX_INIT;
			m_min    <= OMIN_INIT;
			m_init   <= OINIT_INIT;
			m_mult   <= MULT_INIT;
			m_prev   <= OINIT_INIT;
			m_scaled <= 0;
			m_cnt    <= 0;
			m_reload <= 1'b0;
			exp_data <= '0;
		end else begin
			m_reload <= update_in && update_en_in;
			if (update_in && update_en_in) begin
				m_max  <= int'(output_max_in);
				m_min  <= int'(output_min_in);
				m_init <= int'(output_init_in);
				m_mult <= int'(multiplier_in);
			end
			if (m_cnt == 0) begin
				if (data_valid_in) begin
					m_cnt    <= SEQ_CYCLES;	// accepted only when idle
					m_scaled <= scale_sample(data_in, m_mult);
				end
			end else begin
				m_cnt <= m_cnt - 1;
			end
			if (m_cnt == LATCH_AT) begin
				exp_data <= W_OUT'(latch_word(lock_en_in, m_scaled, m_prev,
					m_init, m_min, m_max));
			end
			if (m_reload) begin
				m_prev <= m_init;	// reload beats write-back
			end else if (m_cnt == COMMIT_AT) begin
				m_prev <= int'(exp_data);
			end
		end
	end

	always @(posedge clk_in) begin
		if (!reset_in && data_valid_out) n_pulses <= n_pulses + 1;
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_valid: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out == exp_valid)
		else begin
			mismatch_errors++;
			$display("mismatch data_valid_out: got %h expected %h",
				$sampled(data_valid_out), $sampled(exp_valid));
		end

	a_data: assert property (@(posedge clk_in) disable iff (reset_in)
		data_out == exp_data)
		else begin
			mismatch_errors++;
			$display("mismatch data_out: got %h expected %h",
				$sampled(data_out), $sampled(exp_data));
		end

	a_in_bounds: assert property (@(posedge clk_in) disable iff (reset_in)
		(data_valid_out && (m_min <= m_max))
		|-> ((int'(data_out) >= m_min) && (int'(data_out) <= m_max)))
		else begin
			other_errors++;
			$display("output word %h went out while outside the active bounds",
				$sampled(data_out));
		end

	a_send_to_done: assert property (@(posedge clk_in) disable iff (reset_in)
		(DUT.u_control.state == opp_pkg::st_send) |=> (DUT.u_control.state == opp_pkg::st_done))
		else begin
			other_errors++;
			$display("sequencer did not step from send to done");
		end

	a_done_to_idle: assert property (@(posedge clk_in) disable iff (reset_in)
		(DUT.u_control.state == opp_pkg::st_done) |=> (DUT.u_control.state == opp_pkg::st_idle))
		else begin
			other_errors++;
			$display("sequencer did not return to idle after done");
		end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);	// one step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// starts and ends on a falling edge with the stage idle
	task automatic send_sample(input logic signed [W_IN-1:0] s, input logic extra);
		data_in       = s;
		data_valid_in = 1'b1;
		n_sent++;
		@(negedge clk_in);
		data_valid_in = 1'b0;
		if (extra) begin
			@(negedge clk_in);
			data_in       = ~s;	// lands in compute, must be dropped
			data_valid_in = 1'b1;
			@(negedge clk_in);
			data_valid_in = 1'b0;
		end
		while (!data_valid_out) @(negedge clk_in);	// wait for the pulse
		@(negedge clk_in);
		data_valid_in = extra;	// lands in done when set
		@(negedge clk_in);
		data_valid_in = 1'b0;
	endtask

	task automatic run_random(input int count, input logic extra);
		logic [31:0]            raw;
		logic [31:0]            shift;
		logic signed [W_IN-1:0] sample;
		for (int i = 0; i < count; i++) begin
			take_bits(W_IN, raw);
			take_bits(4, shift);
			sample = $signed(raw[W_IN-1:0]) >>> shift[3:0];	// mixed magnitudes
			send_sample(sample, extra);
		end
	endtask

	task automatic load_params(input int omax, input int omin, input int oinit,
		input int mult, input logic enable);
		output_max_in  = W_OUT'(omax);
		output_min_in  = W_OUT'(omin);
		output_init_in = W_OUT'(oinit);
		multiplier_in  = (opp_pkg::MULT_W)'(mult);
		update_en_in   = enable;
		update_in      = 1'b1;
		@(negedge clk_in);
		update_in    = 1'b0;
		update_en_in = 1'b0;
		repeat (2) @(negedge clk_in);	// reload settles
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
		if ((mismatch_errors == 0) && (other_errors == 0)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		data_in        = '0;
		data_valid_in  = 1'b0;
		lock_en_in     = 1'b1;
		output_max_in  = W_OUT'(OMAX_INIT);
		output_min_in  = W_OUT'(OMIN_INIT);
		output_init_in = W_OUT'(OINIT_INIT);
		multiplier_in  = (opp_pkg::MULT_W)'(MULT_INIT);
		update_en_in   = 1'b0;
		update_in      = 1'b0;
		lfsr           = 32'he93f;
		@(negedge clk_in);
		while (reset_in) @(negedge clk_in);
		repeat (4) @(negedge clk_in);	// quiet after reset

		send_sample(18'sd4000, 1'b0);	// reset parameters, plain add
		send_sample(18'sd20000, 1'b0);	// pushes past max
		send_sample(-18'sd40000, 1'b0);	// drops below min
		send_sample(18'sd1024, 1'b0);
		run_random(N_DROP, 1'b1);	// strobes outside idle

		load_params(WORD_MAX, WORD_MIN, 0, 200, 1'b1);	// wide bounds, big factor
		run_random(N_SAT, 1'b0);

		load_params(500, -300, 100, 3, 1'b1);	// narrow bounds
		run_random(N_NARROW, 1'b0);

		lock_en_in = 1'b0;
		run_random(N_UNLOCK, 1'b0);
		lock_en_in = 1'b1;
		run_random(N_RELOCK, 1'b0);	// accumulates from starting value

		load_params(1000, -1000, -500, 7, 1'b0);	// not armed, no effect
		run_random(N_NOLOAD, 1'b0);
		load_params(2000, -2000, -700, 2, 1'b1);	// restart from new init
		run_random(N_RESTART, 1'b0);

		repeat (4) @(negedge clk_in);
		if (n_pulses != n_sent) begin
			other_errors++;
			$display("saw %0d output pulses for %0d accepted samples", n_pulses, n_sent);
		end
		finish_run();
	end

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_in);
			cycle_count++;
		end
		other_errors++;
		$display("timeout after %0d cycles with the test sequence unfinished", cycle_count);
		finish_run();
	end

endmodule

// File: lock_output_stage.f
common/opp_pkg.sv
common/opp_param_if.sv
output_preprocessor/opp_control.sv
output_preprocessor/opp_param_bank.sv
output_preprocessor/opp_scaler.sv
output_preprocessor/opp_accumulator.sv
output_preprocessor/opp_limiter.sv
source/lock_output_stage.sv
sim/tb_clock_gen.sv
sim/lock_output_stage_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f lock_output_stage.f --top-module lock_output_stage_tb

run: build
	./obj_dir/Vlock_output_stage_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f lock_output_stage.f --top-module lock_output_stage_tb

clean:
	rm -rf obj_dir $(LOG)
